// ==== Makefile ====
# Verilator build and run for the host control fabric

VERILATOR ?= verilator
TOP       ?= neurram_ctrl_tb
FILELIST  ?= neurram_ctrl.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
PASS_MSG  ?= === PASS ===

SOURCES := $(wildcard hw/*.sv dv/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the recipe fails unless the pass line shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/neurram_ctrl_tb.sv ====
// Testbench for the host control fabric.
// Random register traffic, readback, array pin decode and trigger pulse
// timing, checked against reference models of the register map.

module neurram_ctrl_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import neurram_pkg::*;

	typedef logic [44:0] pins_t;	// all decoder pins, packed

	logic       sys_clk;
	logic       arst_n_i;
	logic       host_wr_i;
	host_addr_t host_addr_i;
	word_t      host_wdata_i;
	host_addr_t host_rd_addr_i;
	word_t      host_rdata_o;
	trig_t      status_i;
	trig_t      sys_trig_o, spi_trig_o, neuron_trig_o, dac_trig_o;
	logic       spi_clk_o, neuron_clk_o, dac_clk_o;
	logic [7:0] addr_local_o;
	logic [1:0] select_write_reg_o, vupdate_config_o;
	logic [2:0] addr_horz_o, addr_vert_o;
	logic       clear_horz_b_o, clear_vert_b_o, enable_ota_o, reg_controlled_wl_o;
	logic       ext_1n_o, ext_1n_bl_sel_o, ext_1n_sl_sel_o;
	logic       ext_3n_o, ext_3n_bl_sel_o, ext_3n_sl_sel_o;
	logic       ext_inference_enable_bl_o, ext_inference_enable_sl_o;
	logic       ext_precharge_bl_o, ext_precharge_sl_o, ext_turn_on_wl_o, turn_off_precharge_o;
	logic       forward_o, inference_mode_o, ifat_mode_o, lfsr_mode_o, wupdate_mode_o;
	logic       lfsrhorz_set_b_o, dec_enable_horz_o, dec_enable_vert_o;
	logic       core_enable_clk_o, core_enable_in_o, core_enable_reset_b_o;

	word_t       shadow [256];	// host view of every register
	logic [31:0] lfsr_q;
	int          pass_cnt;
	int          err_cnt;

	reg_addr_e  cfg_addrs [9] = '{ADDR_REG_CTRL, ADDR_LOCAL, ADDR_MODE, ADDR_MISC, ADDR_EXT,
		ADDR_LFSR, ADDR_VUPDATE, ADDR_CORE_ADDR, ADDR_CORE_EN};
	reg_addr_e  field_addrs [7] = '{ADDR_REG_CTRL, ADDR_LOCAL, ADDR_MISC, ADDR_LFSR,
		ADDR_VUPDATE, ADDR_CORE_ADDR, ADDR_CORE_EN};
	host_addr_t other_addrs [8] = '{8'h00, 8'h07, 8'h27, 8'hff,
		ADDR_TRIG_SYS, ADDR_TRIG_DAC, ADDR_TRIG_SPI, ADDR_TRIG_NEURON};
	word_t      mode_set [8] = '{32'h01, 32'h02, 32'h04, 32'h10, 32'h03, 32'h12, 32'h21, 32'h14};
	host_addr_t trig_addr [4] = '{ADDR_TRIG_SYS, ADDR_TRIG_SPI, ADDR_TRIG_NEURON, ADDR_TRIG_DAC};
	int         trig_limit [4] = '{1, 4, 8, 16};	// worst-case cycles to the tick
	string      dom_names [4] = '{"sys", "spi", "neuron", "dac"};

	neurram_ctrl_top dut (.*);

	initial begin
		sys_clk = 1'b0;
		forever #4 sys_clk = ~sys_clk;
	end

	// ------------------------------------------------------------
	// random source and reference models
	// ------------------------------------------------------------
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};	// taps 32 22 2 1
	endfunction

	function automatic word_t rnd(input int nbits);
		word_t r;
		r = '0;
		for (int i = 0; i < nbits; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			r = {r[30:0], lfsr_q[0]};
		end
		return r;
	endfunction

	function automatic logic is_cfg(input host_addr_t a);
		case (a)
			ADDR_REG_CTRL, ADDR_LOCAL, ADDR_MODE, ADDR_MISC, ADDR_EXT, ADDR_LFSR,
			ADDR_VUPDATE, ADDR_CORE_ADDR, ADDR_CORE_EN: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic word_t read_ref(input host_addr_t a);
		if (is_cfg(a)) return shadow[a];
		if (a == ADDR_STATUS) return word_t'(status_i);
		return '0;
	endfunction

	// dac, neuron and spi clocks n cycles out of reset
	function automatic logic [2:0] div_clks(input int n);
		logic [3:0] cnt;
		cnt = n[3:0];
		return {cnt[3], cnt[2], cnt[1]};
	endfunction

	function automatic pins_t ref_pins();
		word_t m, e, c, l, mi, lf, v, ca, ce;
		logic  inf, ifat, lfs, wup, single, inf_m, ifat_m, wup_m;
		m  = shadow[ADDR_MODE];
		e  = shadow[ADDR_EXT];
		c  = shadow[ADDR_REG_CTRL];
		l  = shadow[ADDR_LOCAL];
		mi = shadow[ADDR_MISC];
		lf = shadow[ADDR_LFSR];
		v  = shadow[ADDR_VUPDATE];
		ca = shadow[ADDR_CORE_ADDR];
		ce = shadow[ADDR_CORE_EN];
		inf  = m[MODE_INF_BIT];
		ifat = m[MODE_IFAT_BIT];
		lfs  = m[MODE_LFSR_BIT];
		wup  = m[MODE_WUPD_BIT];
		single = ($countones({inf, ifat, lfs, wup}) == 1);	// any conflict gives no mode
		inf_m  = single & inf;
		ifat_m = single & ifat;
		wup_m  = single & wup;
		return {l[7:0], l[9:8], ~c[0], ~c[1], mi[6], mi[5],
			e[EXT_1N], e[EXT_1N_BL], e[EXT_1N_SL],
			(inf | ifat | lfs) & ~e[EXT_3N_OFF], e[EXT_3N_BL], e[EXT_3N_SL],
			e[EXT_INF_BL] | inf_m | ifat_m, e[EXT_INF_SL] | inf_m | ifat_m,
			e[EXT_PRE_BL] | ifat | inf, e[EXT_PRE_SL] | ifat | inf,
			e[EXT_WL], e[EXT_PRE_OFF], m[MODE_FWD_BIT], inf_m, ifat_m, lfs, wup_m,
			~lf[0], v[1:0], ca[2:0], ca[5:3], ca[6], ca[7], ce[1], ce[2], ~ce[0]};
	endfunction

	function automatic pins_t act_pins();
		return {addr_local_o, select_write_reg_o, clear_horz_b_o, clear_vert_b_o,
			enable_ota_o, reg_controlled_wl_o, ext_1n_o, ext_1n_bl_sel_o, ext_1n_sl_sel_o,
			ext_3n_o, ext_3n_bl_sel_o, ext_3n_sl_sel_o,
			ext_inference_enable_bl_o, ext_inference_enable_sl_o,
			ext_precharge_bl_o, ext_precharge_sl_o, ext_turn_on_wl_o, turn_off_precharge_o,
			forward_o, inference_mode_o, ifat_mode_o, lfsr_mode_o, wupdate_mode_o,
			lfsrhorz_set_b_o, vupdate_config_o, addr_horz_o, addr_vert_o,
			dec_enable_horz_o, dec_enable_vert_o, core_enable_clk_o, core_enable_in_o,
			core_enable_reset_b_o};
	endfunction

	function automatic trig_t bus(input int d);
		case (d)
			0: return sys_trig_o;
			1: return spi_trig_o;
			2: return neuron_trig_o;
			default: return dac_trig_o;
		endcase
	endfunction

	// ------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------
	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp) begin
			err_cnt++;
			$display("[ERROR] %s expected %h actual %h", name, exp, act);
		end else begin
			pass_cnt++;
			$display("ok      %s", name);
		end
	endtask

	task automatic check_trig(input string name, input trig_t exp, input trig_t act);
		if (act !== exp) begin
			err_cnt++;
			$display("[ERROR] %s expected %h actual %h", name, exp, act);
		end else begin
			pass_cnt++;
			$display("ok      %s", name);
		end
	endtask

	task automatic check_pins(input string name, input pins_t exp, input pins_t act);
		if (act !== exp) begin
			err_cnt++;
			$display("[ERROR] %s expected %h actual %h", name, exp, act);
		end else begin
			pass_cnt++;
			$display("ok      %s", name);
		end
	endtask

	// ------------------------------------------------------------
	// host port drivers
	// ------------------------------------------------------------
	task automatic host_write(input host_addr_t a, input word_t d);
		@(posedge sys_clk);
		host_wr_i    <= 1'b1;
		host_addr_i  <= a;
		host_wdata_i <= d;
		@(posedge sys_clk);	// write taken here
		host_wr_i <= 1'b0;
		if (is_cfg(a)) shadow[a] = d;
	endtask

	task automatic write_check(input string name, input host_addr_t a, input word_t d);
		host_write(a, d);
		@(negedge sys_clk);
		check_pins(name, ref_pins(), act_pins());
	endtask

	task automatic read_check(input host_addr_t a);
		@(posedge sys_clk);
		host_rd_addr_i <= a;
		@(posedge sys_clk);
		@(negedge sys_clk);
		check_word($sformatf("read %h", a), read_ref(a), host_rdata_o);
	endtask

	task automatic wait_pulse(input int d, output trig_t val, output int cyc);
		val = '0;
		cyc = 0;
		while (val == '0 && cyc < 40) begin
			@(negedge sys_clk);
			cyc++;
			val = bus(d);
		end
		if (val == '0) begin
			err_cnt++;
			$display("timeout: %s trigger never arrived within 40 cycles", dom_names[d]);
		end
	endtask

	task automatic watch_bus(input int d, input int n, output trig_t seen);
		seen = '0;
		repeat (n) begin
			@(negedge sys_clk);
			seen |= bus(d);
		end
	endtask

	task automatic pulse_test(input int d);
		word_t w;
		trig_t got;
		trig_t extra;
		int    cyc;
		w = rnd(32) | 32'h1;	// upper half must be ignored
		host_write(trig_addr[d], w);
		wait_pulse(d, got, cyc);
		check_trig($sformatf("%s pulse", dom_names[d]), w[15:0], got);
		if (got != '0 && cyc > trig_limit[d]) begin
			err_cnt++;
			$display("%s pulse came %0d cycles after the write, limit is %0d",
				dom_names[d], cyc, trig_limit[d]);
		end
		watch_bus(d, 20, extra);
		check_trig($sformatf("%s single pulse", dom_names[d]), '0, extra);
	endtask

	// ------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------
	initial begin
		trig_t quiet;
		trig_t clk_err;
		trig_t got;
		trig_t extra;
		trig_t t1;
		trig_t t2;
		int    cyc;
		lfsr_q         = 32'hcc8c_8c74;
		arst_n_i       = 1'b0;
		host_wr_i      = 1'b0;
		host_addr_i    = '0;
		host_wdata_i   = '0;
		host_rd_addr_i = '0;
		status_i       = '0;
		pass_cnt       = 0;
		err_cnt        = 0;
		foreach (shadow[i]) shadow[i] = '0;
		repeat (4) @(posedge sys_clk);
		arst_n_i <= 1'b1;

		@(negedge sys_clk);
		check_pins("reset pins", ref_pins(), act_pins());
		check_word("reset rdata", '0, host_rdata_o);
		quiet   = '0;
		clk_err = '0;
		for (int k = 1; k <= 32; k++) begin
			@(negedge sys_clk);
			quiet |= sys_trig_o | spi_trig_o | neuron_trig_o | dac_trig_o;
			clk_err |= trig_t'({dac_clk_o, neuron_clk_o, spi_clk_o} ^ div_clks(k));
		end
		check_trig("reset triggers quiet", '0, quiet);
		check_trig("divided clock mismatch", '0, clk_err);

		// readback of every mapped and unmapped address
		foreach (cfg_addrs[i]) host_write(cfg_addrs[i], rnd(32));
		foreach (cfg_addrs[i]) read_check(cfg_addrs[i]);
		foreach (other_addrs[i]) read_check(other_addrs[i]);
		@(posedge sys_clk);
		status_i <= trig_t'(rnd(16));
		read_check(ADDR_STATUS);

		// mode decode, single bits first and then conflicts
		for (int i = 0; i < 16; i++) begin
			write_check($sformatf("mode %0d", i), ADDR_MODE, (i < 8) ? mode_set[i] : rnd(32));
			write_check($sformatf("ext %0d", i), ADDR_EXT, rnd(32));
		end

		for (int i = 0; i < 6; i++) begin
			foreach (field_addrs[j]) begin
				write_check($sformatf("field %h #%0d", field_addrs[j], i), field_addrs[j], rnd(32));
			end
		end

		// trigger pulses, repeated to land on different divider phases
		for (int i = 0; i < 3; i++) begin
			for (int d = 0; d < 4; d++) pulse_test(d);
		end

		// merged dac writes, aligned just after a dac tick
		host_write(ADDR_TRIG_DAC, 32'h1);
		wait_pulse(3, got, cyc);
		check_trig("dac align pulse", 16'h0001, got);
		t1 = trig_t'(rnd(16)) | 16'h0100;
		t2 = trig_t'(rnd(16));
		host_write(ADDR_TRIG_DAC, word_t'(t1));
		host_write(ADDR_TRIG_DAC, word_t'(t2));
		wait_pulse(3, got, cyc);
		check_trig("dac merged pulse", t1 | t2, got);
		watch_bus(3, 20, extra);
		check_trig("dac merged single pulse", '0, extra);

		$display("checks passed %0d, failed %0d", pass_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	initial begin
		#100_000;
		$display("watchdog expired before the test sequence finished");
		$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== hw/array_mode_decoder.sv ====
// Array mode decoder.
// Purely combinational map of the mode, external, clear and core words
// onto the array's mode, precharge, inference and core pins.

module array_mode_decoder (
	neurram_cfg_if.decoder cfg,
	output logic [7:0]     addr_local_o,
	output logic [1:0]     select_write_reg_o,
	output logic           clear_horz_b_o,
	output logic           clear_vert_b_o,
	output logic           enable_ota_o,
	output logic           reg_controlled_wl_o,
	output logic           ext_1n_o,
	output logic           ext_1n_bl_sel_o,
	output logic           ext_1n_sl_sel_o,
	output logic           ext_3n_o,
	output logic           ext_3n_bl_sel_o,
	output logic           ext_3n_sl_sel_o,
	output logic           ext_inference_enable_bl_o,
	output logic           ext_inference_enable_sl_o,
	output logic           ext_precharge_bl_o,
	output logic           ext_precharge_sl_o,
	output logic           ext_turn_on_wl_o,
	output logic           turn_off_precharge_o,
	output logic           forward_o,
	output logic           inference_mode_o,
	output logic           ifat_mode_o,
	output logic           lfsr_mode_o,
	output logic           wupdate_mode_o,
	output logic           lfsrhorz_set_b_o,
	output logic [1:0]     vupdate_config_o,
	output logic [2:0]     addr_horz_o,
	output logic [2:0]     addr_vert_o,
	output logic           dec_enable_horz_o,
	output logic           dec_enable_vert_o,
	output logic           core_enable_clk_o,
	output logic           core_enable_in_o,
	output logic           core_enable_reset_b_o
);
	import neurram_pkg::*;

	logic        inf_bit;
	logic        ifat_bit;
	logic        lfsr_bit;
	logic        wupd_bit;
	logic [3:0]  mode_sel;
	array_mode_e mode_class;

	assign inf_bit  = cfg.mode_w[MODE_INF_BIT];
	assign ifat_bit = cfg.mode_w[MODE_IFAT_BIT];
	assign lfsr_bit = cfg.mode_w[MODE_LFSR_BIT];
	assign wupd_bit = cfg.mode_w[MODE_WUPD_BIT];
	assign mode_sel = {wupd_bit, lfsr_bit, ifat_bit, inf_bit};

	// ----------------------------------------------------------
	// mode classification
	// ----------------------------------------------------------
	always_comb begin
		if (lfsr_bit) begin
			mode_class = MODE_LFSR;	// lfsr wins any conflict
		end else begin
			case (mode_sel)
				4'b0001: mode_class = MODE_INFERENCE;
				4'b0010: mode_class = MODE_IFAT;
				4'b1000: mode_class = MODE_WUPDATE;
				default: mode_class = MODE_NONE;	// conflicts disable all
			endcase
		end
	end

	assign inference_mode_o = (mode_class == MODE_INFERENCE);
	assign ifat_mode_o      = (mode_class == MODE_IFAT);
	assign wupdate_mode_o   = (mode_class == MODE_WUPDATE);
	assign lfsr_mode_o      = lfsr_bit;
	assign forward_o        = cfg.mode_w[MODE_FWD_BIT];

	// ----------------------------------------------------------
	// derived array pins
	// ----------------------------------------------------------
	assign ext_3n_o = (inf_bit | ifat_bit | lfsr_bit) & ~cfg.ext_w[EXT_3N_OFF];

	assign ext_inference_enable_bl_o = cfg.ext_w[EXT_INF_BL] | inference_mode_o | ifat_mode_o;
	assign ext_inference_enable_sl_o = cfg.ext_w[EXT_INF_SL] | inference_mode_o | ifat_mode_o;

	// precharge follows the raw mode bits
	assign ext_precharge_bl_o = cfg.ext_w[EXT_PRE_BL] | ifat_bit | inf_bit;
	assign ext_precharge_sl_o = cfg.ext_w[EXT_PRE_SL] | ifat_bit | inf_bit;

	// active-low pins
	assign clear_horz_b_o        = ~cfg.ctrl_w[CTRL_CLR_HORZ_BIT];
	assign clear_vert_b_o        = ~cfg.ctrl_w[CTRL_CLR_VERT_BIT];
	assign lfsrhorz_set_b_o      = ~cfg.lfsr_w[LFSR_SET_BIT];
	assign core_enable_reset_b_o = ~cfg.core_en_w[CEN_RST_BIT];

	// straight slices
	assign addr_local_o         = cfg.local_w[7:0];
	assign select_write_reg_o   = cfg.local_w[9:8];
	assign enable_ota_o         = cfg.misc_w[MISC_OTA_BIT];
	assign reg_controlled_wl_o  = cfg.misc_w[MISC_WL_BIT];
	assign ext_1n_o             = cfg.ext_w[EXT_1N];
	assign ext_1n_bl_sel_o      = cfg.ext_w[EXT_1N_BL];
	assign ext_1n_sl_sel_o      = cfg.ext_w[EXT_1N_SL];
	assign ext_3n_bl_sel_o      = cfg.ext_w[EXT_3N_BL];
	assign ext_3n_sl_sel_o      = cfg.ext_w[EXT_3N_SL];
	assign ext_turn_on_wl_o     = cfg.ext_w[EXT_WL];
	assign turn_off_precharge_o = cfg.ext_w[EXT_PRE_OFF];
	assign vupdate_config_o     = cfg.vupdate_w[1:0];
	assign addr_horz_o          = cfg.core_addr_w[2:0];
	assign addr_vert_o          = cfg.core_addr_w[5:3];
	assign dec_enable_horz_o    = cfg.core_addr_w[CADDR_DEC_H_BIT];
	assign dec_enable_vert_o    = cfg.core_addr_w[CADDR_DEC_V_BIT];
	assign core_enable_clk_o    = cfg.core_en_w[CEN_CLK_BIT];
	assign core_enable_in_o     = cfg.core_en_w[CEN_IN_BIT];

endmodule

// ==== hw/host_reg_bank.sv ====
// Host configuration register bank.
// Nine writable words loaded from the host port, driven out on the
// configuration bus, plus a registered readback mux with the status word.

module host_reg_bank (
	input  logic                    sys_clk,
	input  logic                    arst_n_i,
	input  logic                    host_wr_i,
	input  neurram_pkg::host_addr_t host_addr_i,
	input  neurram_pkg::word_t      host_wdata_i,
	input  neurram_pkg::host_addr_t host_rd_addr_i,
	input  neurram_pkg::trig_t      status_i,
	output neurram_pkg::word_t      host_rdata_o,
	neurram_cfg_if.bank             cfg
);
	import neurram_pkg::*;

	word_t ctrl_q;
	word_t local_q;
	word_t mode_q;
	word_t misc_q;
	word_t ext_q;
	word_t lfsr_q;
	word_t vupdate_q;
	word_t core_addr_q;
	word_t core_en_q;

	word_t rd_mux;
	word_t rdata_q;

	// ----------------------------------------------------------
	// host writes
	// ----------------------------------------------------------
	always_ff @(posedge sys_clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ctrl_q      <= '0;
			local_q     <= '0;
			mode_q      <= '0;
			misc_q      <= '0;
			ext_q       <= '0;
			lfsr_q      <= '0;
			vupdate_q   <= '0;
			core_addr_q <= '0;
			core_en_q   <= '0;
		end else if (host_wr_i) begin
			case (host_addr_i)
				ADDR_REG_CTRL:  ctrl_q      <= host_wdata_i;
				ADDR_LOCAL:     local_q     <= host_wdata_i;
				ADDR_MODE:      mode_q      <= host_wdata_i;
				ADDR_MISC:      misc_q      <= host_wdata_i;
				ADDR_EXT:       ext_q       <= host_wdata_i;
				ADDR_LFSR:      lfsr_q      <= host_wdata_i;
				ADDR_VUPDATE:   vupdate_q   <= host_wdata_i;
				ADDR_CORE_ADDR: core_addr_q <= host_wdata_i;
				ADDR_CORE_EN:   core_en_q   <= host_wdata_i;
				default: ;	// triggers and unmapped, nothing stored
			endcase
		end
	end

	// ----------------------------------------------------------
	// readback
	// ----------------------------------------------------------
	always_comb begin
		case (host_rd_addr_i)
			ADDR_REG_CTRL:  rd_mux = ctrl_q;
			ADDR_LOCAL:     rd_mux = local_q;
			ADDR_MODE:      rd_mux = mode_q;
			ADDR_MISC:      rd_mux = misc_q;
			ADDR_EXT:       rd_mux = ext_q;
			ADDR_LFSR:      rd_mux = lfsr_q;
			ADDR_VUPDATE:   rd_mux = vupdate_q;
			ADDR_CORE_ADDR: rd_mux = core_addr_q;
			ADDR_CORE_EN:   rd_mux = core_en_q;
			ADDR_STATUS:    rd_mux = word_t'(status_i);	// zero-extended
			default:        rd_mux = '0;
		endcase
	end

	always_ff @(posedge sys_clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rdata_q <= '0;
		end else begin
			rdata_q <= rd_mux;
		end
	end

	assign host_rdata_o = rdata_q;

	// drive the decoder side
	assign cfg.ctrl_w      = ctrl_q;
	assign cfg.local_w     = local_q;
	assign cfg.mode_w      = mode_q;
	assign cfg.misc_w      = misc_q;
	assign cfg.ext_w       = ext_q;
	assign cfg.lfsr_w      = lfsr_q;
	assign cfg.vupdate_w   = vupdate_q;
	assign cfg.core_addr_w = core_addr_q;
	assign cfg.core_en_w   = core_en_q;

endmodule

// ==== hw/neurram_cfg_if.sv ====
// Configuration bus between the register bank and the mode decoder.
// Carries the registered configuration words as they sit in the bank.

interface neurram_cfg_if;
	import neurram_pkg::*;

	word_t ctrl_w;		// register clears
	word_t local_w;		// [7:0] address, [9:8] write-reg select
	word_t mode_w;
	word_t misc_w;		// [6] ota enable, [5] reg-controlled wl
	word_t ext_w;
	word_t lfsr_w;		// [0] set
	word_t vupdate_w;	// [1:0]
	word_t core_addr_w;	// [2:0] horz, [5:3] vert, [7:6] decoder enables
	word_t core_en_w;	// [0] reset, [1] clk, [2] in

	modport bank (
		output ctrl_w, local_w, mode_w, misc_w, ext_w,
		output lfsr_w, vupdate_w, core_addr_w, core_en_w
	);

	modport decoder (
		input ctrl_w, local_w, mode_w, misc_w, ext_w,
		input lfsr_w, vupdate_w, core_addr_w, core_en_w
	);

endinterface

// ==== hw/neurram_ctrl_top.sv ====
// Host control fabric top level.
// Register bank, trigger pulser and array mode decoder behind a simple
// host register port, all on sys_clk.

module neurram_ctrl_top (
	input  logic                    sys_clk,
	input  logic                    arst_n_i,
	// host port
	input  logic                    host_wr_i,
	input  neurram_pkg::host_addr_t host_addr_i,
	input  neurram_pkg::word_t      host_wdata_i,
	input  neurram_pkg::host_addr_t host_rd_addr_i,
	output neurram_pkg::word_t      host_rdata_o,
	input  neurram_pkg::trig_t      status_i,	// engine idle flags
	// trigger buses and divided clocks
	output neurram_pkg::trig_t      sys_trig_o,
	output neurram_pkg::trig_t      spi_trig_o,
	output neurram_pkg::trig_t      neuron_trig_o,
	output neurram_pkg::trig_t      dac_trig_o,
	output logic                    spi_clk_o,
	output logic                    neuron_clk_o,
	output logic                    dac_clk_o,
	// array pins
	output logic [7:0]              addr_local_o,
	output logic [1:0]              select_write_reg_o,
	output logic                    clear_horz_b_o,
	output logic                    clear_vert_b_o,
	output logic                    enable_ota_o,
	output logic                    reg_controlled_wl_o,
	output logic                    ext_1n_o,
	output logic                    ext_1n_bl_sel_o,
	output logic                    ext_1n_sl_sel_o,
	output logic                    ext_3n_o,
	output logic                    ext_3n_bl_sel_o,
	output logic                    ext_3n_sl_sel_o,
	output logic                    ext_inference_enable_bl_o,
	output logic                    ext_inference_enable_sl_o,
	output logic                    ext_precharge_bl_o,
	output logic                    ext_precharge_sl_o,
	output logic                    ext_turn_on_wl_o,
	output logic                    turn_off_precharge_o,
	output logic                    forward_o,
	output logic                    inference_mode_o,
	output logic                    ifat_mode_o,
	output logic                    lfsr_mode_o,
	output logic                    wupdate_mode_o,
	output logic                    lfsrhorz_set_b_o,
	output logic [1:0]              vupdate_config_o,
	// core select
	output logic [2:0]              addr_horz_o,
	output logic [2:0]              addr_vert_o,
	output logic                    dec_enable_horz_o,
	output logic                    dec_enable_vert_o,
	output logic                    core_enable_clk_o,
	output logic                    core_enable_in_o,
	output logic                    core_enable_reset_b_o
);

	neurram_cfg_if cfg_bus ();

	host_reg_bank u_reg_bank (
		.sys_clk        (sys_clk),
		.arst_n_i       (arst_n_i),
		.host_wr_i      (host_wr_i),
		.host_addr_i    (host_addr_i),
		.host_wdata_i   (host_wdata_i),
		.host_rd_addr_i (host_rd_addr_i),
		.status_i       (status_i),
		.host_rdata_o   (host_rdata_o),
		.cfg            (cfg_bus.bank)
	);

	trigger_pulser u_trig (
		.sys_clk       (sys_clk),
		.arst_n_i      (arst_n_i),
		.host_wr_i     (host_wr_i),
		.host_addr_i   (host_addr_i),
		.host_wdata_i  (host_wdata_i),
		.sys_trig_o    (sys_trig_o),
		.spi_trig_o    (spi_trig_o),
		.neuron_trig_o (neuron_trig_o),
		.dac_trig_o    (dac_trig_o),
		.spi_clk_o     (spi_clk_o),
		.neuron_clk_o  (neuron_clk_o),
		.dac_clk_o     (dac_clk_o)
	);

	// pin names match one to one
	array_mode_decoder u_decode (
		.cfg (cfg_bus.decoder),
		.*
	);

endmodule

// ==== hw/neurram_pkg.sv ====
// Host control fabric package for the resistive-memory compute test chip.
// Holds the endpoint address map, register field positions, word types
// and the decoded array mode encoding.

package neurram_pkg;

	typedef logic [7:0]  host_addr_t;
	typedef logic [31:0] word_t;
	typedef logic [15:0] trig_t;	// one bit per trigger line

	// ----------------------------------------------------------
	// endpoint address map
	// ----------------------------------------------------------
	typedef enum logic [7:0] {
		ADDR_REG_CTRL    = 8'h03,	// register clears
		ADDR_LOCAL       = 8'h04,	// local address, write-reg select
		ADDR_MODE        = 8'h05,
		ADDR_MISC        = 8'h06,
		ADDR_EXT         = 8'h08,	// external pin overrides
		ADDR_LFSR        = 8'h0A,
		ADDR_VUPDATE     = 8'h0B,
		ADDR_CORE_ADDR   = 8'h13,
		ADDR_CORE_EN     = 8'h14,
		ADDR_STATUS      = 8'h28,	// engine idle flags, read only
		ADDR_TRIG_SYS    = 8'h40,
		ADDR_TRIG_DAC    = 8'h41,
		ADDR_TRIG_SPI    = 8'h44,
		ADDR_TRIG_NEURON = 8'h45
	} reg_addr_e;

	typedef enum logic [2:0] {
		MODE_NONE,
		MODE_INFERENCE,
		MODE_IFAT,
		MODE_WUPDATE,
		MODE_LFSR
	} array_mode_e;

	// clock divider, 100 MHz base
	localparam int DIV_W          = 4;
	localparam int DIV_SPI_BIT    = 1;	// 25 MHz
	localparam int DIV_NEURON_BIT = 2;	// 12.5 MHz
	localparam int DIV_DAC_BIT    = 3;	// 6.25 MHz
	localparam int N_TRIG_DOM     = 4;	// sys, spi, neuron, dac

	// mode register
	localparam int MODE_INF_BIT  = 0;
	localparam int MODE_IFAT_BIT = 1;
	localparam int MODE_LFSR_BIT = 2;
	localparam int MODE_WUPD_BIT = 4;
	localparam int MODE_FWD_BIT  = 5;

	// external control register
	localparam int EXT_3N_OFF  = 0;
	localparam int EXT_3N_BL   = 1;
	localparam int EXT_3N_SL   = 2;
	localparam int EXT_1N      = 3;
	localparam int EXT_1N_BL   = 4;
	localparam int EXT_1N_SL   = 5;
	localparam int EXT_PRE_BL  = 6;
	localparam int EXT_PRE_SL  = 7;
	localparam int EXT_INF_BL  = 8;
	localparam int EXT_INF_SL  = 9;
	localparam int EXT_WL      = 10;
	localparam int EXT_PRE_OFF = 11;

	// single-bit fields of the remaining registers
	localparam int CTRL_CLR_HORZ_BIT = 0;
	localparam int CTRL_CLR_VERT_BIT = 1;
	localparam int MISC_WL_BIT       = 5;
	localparam int MISC_OTA_BIT      = 6;
	localparam int LFSR_SET_BIT      = 0;
	localparam int CADDR_DEC_H_BIT   = 6;
	localparam int CADDR_DEC_V_BIT   = 7;
	localparam int CEN_RST_BIT       = 0;
	localparam int CEN_CLK_BIT       = 1;
	localparam int CEN_IN_BIT        = 2;

endpackage

// ==== hw/trigger_pulser.sv ====
// Trigger pulser.
// Free-running clock divider plus one pending trigger word per domain.
// Host writes arm bits, which are released as a one-cycle pulse on the
// next tick of their domain.

module trigger_pulser (
	input  logic                    sys_clk,
	input  logic                    arst_n_i,
	input  logic                    host_wr_i,
	input  neurram_pkg::host_addr_t host_addr_i,
	input  neurram_pkg::word_t      host_wdata_i,
	output neurram_pkg::trig_t      sys_trig_o,
	output neurram_pkg::trig_t      spi_trig_o,
	output neurram_pkg::trig_t      neuron_trig_o,
	output neurram_pkg::trig_t      dac_trig_o,
	output logic                    spi_clk_o,
	output logic                    neuron_clk_o,
	output logic                    dac_clk_o
);
	import neurram_pkg::*;

	// domain index order: 0 sys, 1 spi, 2 neuron, 3 dac
	logic [DIV_W-1:0]      div_q;
	logic [N_TRIG_DOM-1:0] tick;
	logic [N_TRIG_DOM-1:0] hit;
	trig_t                 arm;
	trig_t                 pend_q [N_TRIG_DOM];
	trig_t                 fire [N_TRIG_DOM];

	// ----------------------------------------------------------
	// clock divider
	// ----------------------------------------------------------
	always_ff @(posedge sys_clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			div_q <= '0;
		end else begin
			div_q <= div_q + DIV_W'(1);
		end
	end

	assign spi_clk_o    = div_q[DIV_SPI_BIT];
	assign neuron_clk_o = div_q[DIV_NEURON_BIT];
	assign dac_clk_o    = div_q[DIV_DAC_BIT];

	// tick when every divider bit up to the domain bit is set
	assign tick[0] = 1'b1;
	assign tick[1] = &div_q[DIV_SPI_BIT:0];
	assign tick[2] = &div_q[DIV_NEURON_BIT:0];
	assign tick[3] = &div_q[DIV_DAC_BIT:0];

	// ----------------------------------------------------------
	// capture and release
	// ----------------------------------------------------------
	assign arm    = host_wdata_i[$bits(trig_t)-1:0];
	assign hit[0] = host_wr_i && (host_addr_i == ADDR_TRIG_SYS);
	assign hit[1] = host_wr_i && (host_addr_i == ADDR_TRIG_SPI);
	assign hit[2] = host_wr_i && (host_addr_i == ADDR_TRIG_NEURON);
	assign hit[3] = host_wr_i && (host_addr_i == ADDR_TRIG_DAC);

	always_ff @(posedge sys_clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int d = 0; d < N_TRIG_DOM; d++) begin
				pend_q[d] <= '0;
			end
		end else begin
			for (int d = 0; d < N_TRIG_DOM; d++) begin
				// released bits drop, a new write ORs in on top
				pend_q[d] <= (tick[d] ? '0 : pend_q[d]) | (hit[d] ? arm : '0);
			end
		end
	end

	always_comb begin
		for (int d = 0; d < N_TRIG_DOM; d++) begin
			fire[d] = tick[d] ? pend_q[d] : '0;
		end
	end

	assign sys_trig_o    = fire[0];
	assign spi_trig_o    = fire[1];
	assign neuron_trig_o = fire[2];
	assign dac_trig_o    = fire[3];

endmodule

// ==== neurram_ctrl.f ====
hw/neurram_pkg.sv
hw/neurram_cfg_if.sv
hw/host_reg_bank.sv
hw/trigger_pulser.sv
hw/array_mode_decoder.sv
hw/neurram_ctrl_top.sv
dv/neurram_ctrl_tb.sv
